//--- files.f
design/lv_pkg.sv
design/lv_com_rd_reg_proc.sv
design/lv_cmd_decode.sv
design/lv_reg_exec.sv
design/lv_rsp_result.sv
design/lv_reg_top.sv
verification/lv_reg_tb.sv

//--- Makefile
# Verilator build of the lv register block testbench

TOP := lv_reg_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir -o sim

# a failing run ends in $$fatal, which gives a non-zero exit status
run: compile
	./obj_dir/sim

clean:
	rm -rf obj_dir

//--- verification/lv_reg_tb.sv
// simulation top for the lv register block that applies a step table and checks the results
`timescale 1ns/1ps

module lv_reg_tb;
    import lv_pkg::*;

    localparam int CMD_DEPTH   = 4;
    localparam int RSP_DEPTH   = 4;
    localparam int RSP_CREDITS = 2;
    localparam int RST_CYCLES  = 8;
    localparam int BURST_LEN   = 8;

    typedef enum logic [1:0] {
        S_CMD  = 2'd0,
        S_EVT  = 2'd1,
        S_HOLD = 2'd2,
        S_FREE = 2'd3
    } step_kind_e;

    typedef struct packed {
        step_kind_e        kind;
        lv_frame_t         frame;
        logic              rsp_due;
        lv_stat_t          lv_evt;
        lv_stat_t          hv_evt;
        logic              check;
        lv_flt_t           exp_flt;
        logic              exp_int;
        logic [REG_DW-1:0] exp_cfg;
        logic [7:0]        arg;
    } step_t;

    logic              i_clk;
    logic              i_rst_n;
    logic              i_cmd_valid;
    lv_frame_t         i_cmd;
    logic              o_cmd_credit;
    lv_stat_t          i_lv_evt;
    lv_stat_t          i_hv_evt;
    logic              o_rsp_valid;
    lv_rsp_t           o_rsp;
    logic              i_rsp_credit = 1'b0;
    lv_flt_t           o_flt;
    logic              o_int;
    logic [REG_DW-1:0] o_config;

    // step table and expected responses in order are filled before reset
    step_t   steps[$];
    lv_rsp_t rsp_list[$];

    // reference model of the register map
    lv_stat_t          m_lv;
    lv_stat_t          m_hv;
    logic [REG_DW-1:0] m_mask1;
    logic [REG_DW-1:0] m_mask2;
    logic [REG_DW-1:0] m_cfg;
    logic [31:0]       rng;
    logic              in_burst;

    // host side bookkeeping
    int   cmd_sent;
    int   rsp_due_total;
    int   cmd_returned = 0;
    int   rsp_seen = 0;
    int   hold_seen = 0;
    int   owed = 0;
    logic credits_on;

    lv_reg_top #(
        .CMD_DEPTH   (CMD_DEPTH),
        .RSP_DEPTH   (RSP_DEPTH),
        .RSP_CREDITS (RSP_CREDITS)
    ) dut_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd        (i_cmd),
        .o_cmd_credit (o_cmd_credit),
        .i_lv_evt     (i_lv_evt),
        .i_hv_evt     (i_hv_evt),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp        (o_rsp),
        .i_rsp_credit (i_rsp_credit),
        .o_flt        (o_flt),
        .o_int        (o_int),
        .o_config     (o_config)
    );

    always #5 i_clk = ~i_clk;

    // ==================
    // checks
    // ==================
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_rsp(input lv_rsp_t exp, input lv_rsp_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf(
                "[ERROR] time=%0t o_rsp addr/data/err expected=%h/%h/%b actual=%h/%h/%b",
                $time, exp.addr, exp.data, exp.err, act.addr, act.data, act.err));
        end
    endtask

    task automatic check_flt(input lv_flt_t exp, input lv_flt_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("[ERROR] time=%0t o_flt expected=%h actual=%h",
                $time, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("[ERROR] time=%0t %s expected=%b actual=%b",
                $time, name, exp, act));
        end
    endtask

    task automatic check_cfg(input logic [REG_DW-1:0] exp, input logic [REG_DW-1:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("[ERROR] time=%0t o_config expected=%h actual=%h",
                $time, exp, act));
        end
    endtask

    // ==================
    // model and table
    // ==================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] rand_byte();
        rng = xorshift32(rng);
        return rng[7:0];
    endfunction

    function automatic lv_stat_t rand_stat();
        lv_stat_t s;
        s = '0;
        for (int i = 0; i < 6; i++) begin
            s = {s[39:0], rand_byte()};
        end
        return s;
    endfunction

    function automatic lv_frame_t make_frame(input lv_op_e op, input logic [3:0] a,
                                             input logic [7:0] d, input logic bad);
        lv_frame_t f;
        f.opcode = op;
        f.addr   = a;
        f.data   = d;
        // even parity that can be broken on purpose
        f.parity = ^{f.opcode, f.addr, f.data} ^ bad;
        return f;
    endfunction

    // bits cleared by a write of d to status or bist address a
    function automatic lv_stat_t clr_bits(input logic [3:0] a, input logic [7:0] d);
        lv_stat_t c;
        c = '0;
        case (a)
            A_STATUS1: c.status1 = d;
            A_STATUS2: c.status2 = d;
            A_STATUS3: c.status3 = d;
            A_STATUS4: c.status4 = d;
            A_BIST1:   c.bist1   = d;
            A_BIST2:   c.bist2   = d;
            default:   c         = '0;
        endcase
        return c;
    endfunction

    function automatic void model_write(input logic [3:0] a, input logic [7:0] d);
        m_lv = m_lv & ~clr_bits(a, d);
        m_hv = m_hv & ~clr_bits(a, d);
        case (a)
            A_MASK1:  m_mask1 = d;
            A_MASK2:  m_mask2 = d;
            A_CONFIG: m_cfg   = d;
            default:  ;
        endcase
    endfunction

    function automatic lv_rsp_t model_read(input logic [3:0] a);
        lv_stat_t mg;
        lv_rsp_t  r;
        mg     = m_lv | m_hv;
        r.addr = a;
        r.err  = 1'b0;
        case (a)
            A_STATUS1: r.data = mg.status1;
            A_STATUS2: r.data = mg.status2;
            A_STATUS3: r.data = mg.status3;
            A_STATUS4: r.data = mg.status4;
            A_BIST1:   r.data = mg.bist1;
            A_BIST2:   r.data = mg.bist2;
            A_MASK1:   r.data = m_mask1;
            A_MASK2:   r.data = m_mask2;
            A_CONFIG:  r.data = m_cfg;
            default: begin
                r.data = '0;
                r.err  = 1'b1;
            end
        endcase
        return r;
    endfunction

    // flags are merged status1/status2 with the mask bits removed and status1 bit 6 dropped
    function automatic lv_flt_t model_flt();
        logic [7:0] en1;
        logic [7:0] en2;
        en1 = (m_lv.status1 | m_hv.status1) & ~m_mask1;
        en2 = (m_lv.status2 | m_hv.status2) & ~m_mask2;
        return {en1[7], en1[5:0], en2};
    endfunction

    function automatic void push_step(input step_t s, input logic chk);
        s.check   = chk;
        s.exp_flt = model_flt();
        s.exp_int = |s.exp_flt;
        s.exp_cfg = m_cfg;
        steps.push_back(s);
    endfunction

    function automatic void add_cmd(input lv_op_e op, input logic [3:0] a,
                                    input logic [7:0] d, input logic bad);
        step_t s;
        s       = '0;
        s.kind  = S_CMD;
        s.frame = make_frame(op, a, d, bad);
        if (bad) begin
            // dropped frame shows up as com_err
            m_lv.status1[2] = 1'b1;
        end else if (op == OP_RD) begin
            s.rsp_due = 1'b1;
            rsp_list.push_back(model_read(a));
        end else if (op == OP_WR) begin
            model_write(a, d);
        end
        push_step(s, !in_burst);
    endfunction

    function automatic void add_evt(input lv_stat_t lv, input lv_stat_t hv);
        step_t s;
        s        = '0;
        s.kind   = S_EVT;
        s.lv_evt = lv;
        s.hv_evt = hv;
        m_lv     = m_lv | lv;
        m_hv     = m_hv | hv;
        push_step(s, 1'b1);
    endfunction

    function automatic void add_ctrl(input step_kind_e k, input logic [7:0] arg);
        step_t s;
        s      = '0;
        s.kind = k;
        s.arg  = arg;
        push_step(s, k == S_FREE);
    endfunction

    function automatic void build_table();
        lv_stat_t   lv;
        lv_stat_t   hv;
        logic [7:0] d1;
        logic [7:0] d2;
        logic [7:0] d3;
        // round trip through mask and config and then unmapped reads
        d1 = rand_byte();
        d2 = rand_byte();
        d3 = rand_byte();
        add_cmd(OP_WR, A_MASK1, d1, 1'b0);
        add_cmd(OP_WR, A_MASK2, d2, 1'b0);
        add_cmd(OP_WR, A_CONFIG, d3, 1'b0);
        add_cmd(OP_RD, A_MASK1, 8'h00, 1'b0);
        add_cmd(OP_RD, A_MASK2, 8'h00, 1'b0);
        add_cmd(OP_RD, A_CONFIG, 8'h00, 1'b0);
        add_cmd(OP_RD, 4'd9, 8'h00, 1'b0);
        add_cmd(OP_WR, 4'd15, 8'hff, 1'b0);
        add_cmd(OP_RD, 4'd15, 8'h00, 1'b0);
        add_cmd(OP_WR, A_MASK1, 8'h00, 1'b0);
        add_cmd(OP_WR, A_MASK2, 8'h00, 1'b0);

        // lv/hv merge
        lv         = '0;
        hv         = '0;
        lv.status1 = 8'h01;
        lv.status2 = 8'h80;
        lv.status3 = 8'h0f;
        lv.bist1   = 8'h11;
        hv.status1 = 8'h08;
        hv.status2 = 8'h03;
        hv.status4 = 8'ha0;
        hv.bist2   = 8'h42;
        add_evt(lv, hv);
        lv         = '0;
        hv         = '0;
        lv.status3 = 8'h30;
        lv.bist1   = 8'h02;
        hv.status1 = 8'h80;
        hv.status3 = 8'h01;
        add_evt(lv, hv);
        for (int i = 0; i < 6; i++) begin
            add_cmd(OP_RD, 4'(i), 8'h00, 1'b0);
        end

        // masking hides bits 0 and 3 of status1 and bits 0 and 7 of status2
        add_cmd(OP_WR, A_MASK1, 8'h09, 1'b0);
        add_cmd(OP_WR, A_MASK2, 8'h81, 1'b0);
        lv         = '0;
        hv         = '0;
        lv.status1 = 8'h21;
        hv.status2 = 8'h44;
        add_evt(lv, hv);

        // write-1-to-clear on both sides
        add_cmd(OP_WR, A_STATUS1, 8'hff, 1'b0);
        add_cmd(OP_WR, A_STATUS2, 8'h81, 1'b0);
        add_cmd(OP_WR, A_BIST1, 8'h01, 1'b0);
        add_cmd(OP_RD, A_STATUS1, 8'h00, 1'b0);
        add_cmd(OP_RD, A_STATUS2, 8'h00, 1'b0);
        add_cmd(OP_RD, A_BIST1, 8'h00, 1'b0);

        // bad parity is dropped and flagged
        add_cmd(OP_WR, A_CONFIG, 8'h5a, 1'b1);
        add_cmd(OP_RD, A_STATUS1, 8'h00, 1'b0);
        add_cmd(OP_RD, A_CONFIG, 8'h00, 1'b0);

        // read burst with response credits held back
        add_cmd(OP_WR, A_MASK1, 8'h00, 1'b0);
        add_cmd(OP_WR, A_MASK2, 8'h00, 1'b0);
        add_evt(rand_stat(), rand_stat());
        add_ctrl(S_HOLD, 8'd0);
        in_burst = 1'b1;
        for (int i = 0; i < BURST_LEN; i++) begin
            add_cmd(OP_RD, 4'(i), 8'h00, 1'b0);
        end
        in_burst = 1'b0;
        add_ctrl(S_FREE, 8'(BURST_LEN - RSP_DEPTH - RSP_CREDITS));
        for (int i = 0; i < 6; i++) begin
            add_cmd(OP_WR, 4'(i), 8'hff, 1'b0);
            add_cmd(OP_RD, 4'(i), 8'h00, 1'b0);
        end
    endfunction

    // ==================
    // host driver
    // ==================
    task automatic wait_idle();
        do begin
            @(posedge i_clk);
            i_cmd_valid <= 1'b0;
            if (rsp_seen > rsp_due_total) begin
                stop_with_failure("a response arrived that no read asked for");
            end
        end while (cmd_sent != cmd_returned || rsp_seen != rsp_due_total);
    endtask

    task automatic run_step(input step_t s);
        @(posedge i_clk);
        i_cmd_valid <= 1'b0;
        i_lv_evt    <= '0;
        i_hv_evt    <= '0;
        case (s.kind)
            S_CMD: begin
                // only send while a command credit is held
                while (cmd_sent - cmd_returned >= CMD_DEPTH) begin
                    @(posedge i_clk);
                end
                i_cmd       <= s.frame;
                i_cmd_valid <= 1'b1;
                cmd_sent++;
                if (s.rsp_due) begin
                    rsp_due_total++;
                end
            end
            S_EVT: begin
                i_lv_evt <= s.lv_evt;
                i_hv_evt <= s.hv_evt;
            end
            S_HOLD: begin
                wait_idle();
                credits_on <= 1'b0;
            end
            S_FREE: begin
                // wait until the fifo is full and the rest sits in the command buffer
                while (hold_seen != RSP_CREDITS || cmd_sent - cmd_returned != int'(s.arg)) begin
                    @(posedge i_clk);
                end
                credits_on <= 1'b1;
            end
            default: stop_with_failure("the step table holds an unknown step kind");
        endcase
        if (s.check) begin
            if (s.kind == S_EVT) begin
                @(posedge i_clk);
                i_lv_evt <= '0;
                i_hv_evt <= '0;
            end else begin
                wait_idle();
            end
            @(negedge i_clk);
            check_flt(s.exp_flt, o_flt);
            check_bit("o_int", s.exp_int, o_int);
            check_cfg(s.exp_cfg, o_config);
        end
    endtask

    // response monitor and response credit return
    always @(posedge i_clk) begin
        if (o_cmd_credit) begin
            cmd_returned <= cmd_returned + 1;
        end
        if (o_rsp_valid) begin
            if (rsp_seen >= rsp_list.size()) begin
                stop_with_failure("a response arrived after all expected responses");
            end else begin
                check_rsp(rsp_list[rsp_seen], o_rsp);
            end
            rsp_seen <= rsp_seen + 1;
            owed = owed + 1;
        end
        if (credits_on) begin
            hold_seen <= 0;
        end else if (o_rsp_valid) begin
            if (hold_seen >= RSP_CREDITS) begin
                stop_with_failure("more responses than response credits while credits were held");
            end else begin
                hold_seen <= hold_seen + 1;
            end
        end
        if (credits_on && owed > 0) begin
            i_rsp_credit <= 1'b1;
            owed = owed - 1;
        end else begin
            i_rsp_credit <= 1'b0;
        end
    end

    initial begin
        #1;
        repeat (steps.size() * 50 + RST_CYCLES) @(posedge i_clk);
        stop_with_failure("the run hung, the watchdog expired before the step table finished");
    end

    initial begin
        i_clk         = 1'b0;
        i_rst_n       = 1'b0;
        i_cmd_valid   = 1'b0;
        i_cmd         = '0;
        i_lv_evt      = '0;
        i_hv_evt      = '0;
        credits_on    = 1'b1;
        cmd_sent      = 0;
        rsp_due_total = 0;
        m_lv          = '0;
        m_hv          = '0;
        m_mask1       = '0;
        m_mask2       = '0;
        m_cfg         = '0;
        rng           = 32'd85;
        in_burst      = 1'b0;
        build_table();

        repeat (RST_CYCLES) @(posedge i_clk);
        i_rst_n <= 1'b1;

        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        wait_idle();
        // quiet period so a stray credit or response still shows up
        repeat (CMD_DEPTH + RSP_DEPTH) @(posedge i_clk);

        if (cmd_sent != cmd_returned || rsp_seen != rsp_list.size()) begin
            stop_with_failure("command credits or responses were missing at the end of the run");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

//--- design/lv_reg_top.sv
// top of the lv register block, chains command decode, register execute and response result
`timescale 1ns/1ps

module lv_reg_top #(
    parameter int CMD_DEPTH   = 4,
    parameter int RSP_DEPTH   = 4,
    parameter int RSP_CREDITS = 2
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_cmd_valid,
    input  lv_pkg::lv_frame_t         i_cmd,
    output logic                      o_cmd_credit,
    input  lv_pkg::lv_stat_t          i_lv_evt,
    input  lv_pkg::lv_stat_t          i_hv_evt,
    output logic                      o_rsp_valid,
    output lv_pkg::lv_rsp_t           o_rsp,
    input  logic                      i_rsp_credit,
    output lv_pkg::lv_flt_t           o_flt,
    output logic                      o_int,
    output logic [lv_pkg::REG_DW-1:0] o_config
);
    import lv_pkg::*;

    // decode to execute
    logic    req_valid;
    lv_req_t req;
    logic    exec_ready;
    logic    par_err;

    // execute to result
    logic    rsp_push;
    lv_rsp_t rsp;
    logic    rsp_space;

    lv_cmd_decode #(.CMD_DEPTH(CMD_DEPTH)) decode_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd        (i_cmd),
        .o_cmd_credit (o_cmd_credit),
        .o_req_valid  (req_valid),
        .o_req        (req),
        .i_exec_ready (exec_ready),
        .o_par_err    (par_err)
    );

    lv_reg_exec exec_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_req_valid  (req_valid),
        .i_req        (req),
        .o_exec_ready (exec_ready),
        .i_par_err    (par_err),
        .i_lv_evt     (i_lv_evt),
        .i_hv_evt     (i_hv_evt),
        .o_rsp_push   (rsp_push),
        .o_rsp        (rsp),
        .i_rsp_space  (rsp_space),
        .o_flt        (o_flt),
        .o_int        (o_int),
        .o_config     (o_config)
    );

    lv_rsp_result #(
        .RSP_DEPTH   (RSP_DEPTH),
        .RSP_CREDITS (RSP_CREDITS)
    ) result_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_push       (rsp_push),
        .i_rsp        (rsp),
        .o_space      (rsp_space),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp        (o_rsp),
        .i_rsp_credit (i_rsp_credit)
    );

endmodule

//--- design/lv_rsp_result.sv
// response fifo between the execute stage and the host that releases one read response per credit
`timescale 1ns/1ps

module lv_rsp_result #(
    parameter int RSP_DEPTH   = 4,
    parameter int RSP_CREDITS = 2
) (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_push,
    input  lv_pkg::lv_rsp_t i_rsp,
    output logic            o_space,
    output logic            o_rsp_valid,
    output lv_pkg::lv_rsp_t o_rsp,
    input  logic            i_rsp_credit
);
    import lv_pkg::*;

    localparam int PTR_W  = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
    localparam int CNT_W  = $clog2(RSP_DEPTH + 1);
    localparam int CRED_W = $clog2(RSP_CREDITS + 1);

    lv_rsp_t           fifo_mem [RSP_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] credit_q;
    logic              pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(RSP_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign o_space = (count != CNT_W'(RSP_DEPTH));
    // one response per cycle while a credit is held
    assign pop = (count != '0) & (credit_q != '0);

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            fifo_mem[wr_ptr] <= i_rsp;
        end
        if (pop) begin
            o_rsp <= fifo_mem[rd_ptr];
        end
    end

    // ==================
    // pointers and credits
    // ==================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            credit_q    <= CRED_W'(RSP_CREDITS);
            o_rsp_valid <= 1'b0;
        end else begin
            if (i_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count       <= count + CNT_W'(i_push) - CNT_W'(pop);
            // returned credit and spend may share a cycle
            credit_q    <= credit_q + CRED_W'(i_rsp_credit) - CRED_W'(pop);
            o_rsp_valid <= pop;
        end
    end

    a_credit_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        credit_q <= CRED_W'(RSP_CREDITS))
        else $error("host returned more response credits than issued");

    // execute pushes only while a slot is free
    a_push_space: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_push |-> o_space)
        else $error("response pushed without space");

endmodule

//--- design/lv_reg_exec.sv
// register execute stage used by the top level to keep sticky lv/hv status and run host reads and writes
`timescale 1ns/1ps

module lv_reg_exec (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_req_valid,
    input  lv_pkg::lv_req_t           i_req,
    output logic                      o_exec_ready,
    input  logic                      i_par_err,
    input  lv_pkg::lv_stat_t          i_lv_evt,
    input  lv_pkg::lv_stat_t          i_hv_evt,
    output logic                      o_rsp_push,
    output lv_pkg::lv_rsp_t           o_rsp,
    input  logic                      i_rsp_space,
    output lv_pkg::lv_flt_t           o_flt,
    output logic                      o_int,
    output logic [lv_pkg::REG_DW-1:0] o_config
);
    import lv_pkg::*;

    lv_stat_t          lv_stat_q;
    lv_stat_t          hv_stat_q;
    lv_stat_t          merged;
    lv_stat_t          lv_set;
    lv_stat_t          clr;
    logic [REG_DW-1:0] mask1_q;
    logic [REG_DW-1:0] mask2_q;
    logic [REG_DW-1:0] cfg_q;
    logic              req_fire;
    logic              wr_fire;

    // reads wait for a result slot while writes and nops never do
    assign o_exec_ready = (i_req.op != OP_RD) | i_rsp_space;
    assign req_fire     = i_req_valid & o_exec_ready;
    assign wr_fire      = req_fire & (i_req.op == OP_WR) & i_req.mapped;
    assign o_rsp_push   = req_fire & (i_req.op == OP_RD);
    assign o_config     = cfg_q;

    // ==================
    // sticky status
    // ==================
    // dropped frame reports as com_err on the lv side
    always_comb begin
        lv_set            = i_lv_evt;
        lv_set.status1[2] = i_lv_evt.status1[2] | i_par_err;
    end

    // write-1-to-clear hits the same bits on both copies
    always_comb begin
        clr = '0;
        if (wr_fire) begin
            case (i_req.addr)
                A_STATUS1: clr.status1 = i_req.data;
                A_STATUS2: clr.status2 = i_req.data;
                A_STATUS3: clr.status3 = i_req.data;
                A_STATUS4: clr.status4 = i_req.data;
                A_BIST1:   clr.bist1   = i_req.data;
                A_BIST2:   clr.bist2   = i_req.data;
                default:   clr         = '0;
            endcase
        end
    end

    // set after clear so a same-cycle event survives
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lv_stat_q <= '0;
            hv_stat_q <= '0;
        end else begin
            lv_stat_q <= (lv_stat_q & ~clr) | lv_set;
            hv_stat_q <= (hv_stat_q & ~clr) | i_hv_evt;
        end
    end

    // ==================
    // mask and config
    // ==================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mask1_q <= '0;
            mask2_q <= '0;
            cfg_q   <= '0;
        end else if (wr_fire) begin
            case (i_req.addr)
                A_MASK1:  mask1_q <= i_req.data;
                A_MASK2:  mask2_q <= i_req.data;
                A_CONFIG: cfg_q   <= i_req.data;
                default:  cfg_q   <= cfg_q;
            endcase
        end
    end

    // unmapped reads give err and zero data
    always_comb begin
        o_rsp.addr = i_req.addr;
        o_rsp.data = '0;
        o_rsp.err  = ~i_req.mapped;
        if (i_req.mapped) begin
            case (i_req.addr)
                A_STATUS1: o_rsp.data = merged.status1;
                A_STATUS2: o_rsp.data = merged.status2;
                A_STATUS3: o_rsp.data = merged.status3;
                A_STATUS4: o_rsp.data = merged.status4;
                A_BIST1:   o_rsp.data = merged.bist1;
                A_BIST2:   o_rsp.data = merged.bist2;
                A_MASK1:   o_rsp.data = mask1_q;
                A_MASK2:   o_rsp.data = mask2_q;
                A_CONFIG:  o_rsp.data = cfg_q;
                default:   o_rsp.data = '0;
            endcase
        end
    end

    lv_com_rd_reg_proc rd_proc_i (
        .i_lv_stat (lv_stat_q),
        .i_hv_stat (hv_stat_q),
        .i_mask1   (mask1_q),
        .i_mask2   (mask2_q),
        .o_merged  (merged),
        .o_flt     (o_flt),
        .o_int     (o_int)
    );

endmodule

//--- design/lv_cmd_decode.sv
// command buffer in front of the register block, checks parity and decodes frames into requests
`timescale 1ns/1ps

module lv_cmd_decode #(
    parameter int CMD_DEPTH = 4
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_cmd_valid,
    input  lv_pkg::lv_frame_t  i_cmd,
    output logic               o_cmd_credit,
    output logic               o_req_valid,
    output lv_pkg::lv_req_t    o_req,
    input  logic               i_exec_ready,
    output logic               o_par_err
);
    import lv_pkg::*;

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    lv_frame_t        fifo_mem [CMD_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    lv_frame_t        head;
    logic             empty;
    logic             full;
    logic             head_par_ok;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(CMD_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ==================
    // buffer control
    // ==================
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(CMD_DEPTH));
    assign push  = i_cmd_valid & ~full;
    assign head  = fifo_mem[rd_ptr];

    // even parity, xor of the whole frame is zero
    assign head_par_ok = ~^head;
    assign o_req_valid = ~empty & head_par_ok;
    assign o_par_err   = ~empty & ~head_par_ok;
    // bad frames leave without waiting for execute
    assign pop = o_par_err | (o_req_valid & i_exec_ready);

    always_ff @(posedge i_clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= i_cmd;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            o_cmd_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count        <= count + CNT_W'(push) - CNT_W'(pop);
            o_cmd_credit <= pop;
        end
    end

    // ==================
    // head decode
    // ==================
    always_comb begin
        o_req.data   = head.data;
        o_req.addr   = lv_addr_e'(head.addr);
        o_req.mapped = (head.addr <= A_CONFIG);
        case (head.opcode)
            OP_RD:   o_req.op = OP_RD;
            OP_WR:   o_req.op = OP_WR;
            default: o_req.op = OP_NOP;
        endcase
    end

    // host must hold a credit before it sends
    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_cmd_valid |-> !full)
        else $error("command pushed into full buffer");

endmodule

//--- design/lv_com_rd_reg_proc.sv
// merges lv and hv status copies and masks them into fault flags and the interrupt
`timescale 1ns/1ps

module lv_com_rd_reg_proc (
    input  lv_pkg::lv_stat_t          i_lv_stat,
    input  lv_pkg::lv_stat_t          i_hv_stat,
    input  logic [lv_pkg::REG_DW-1:0] i_mask1,
    input  logic [lv_pkg::REG_DW-1:0] i_mask2,
    output lv_pkg::lv_stat_t          o_merged,
    output lv_pkg::lv_flt_t           o_flt,
    output logic                      o_int
);
    import lv_pkg::*;

    logic [REG_DW-1:0] en1;
    logic [REG_DW-1:0] en2;

    // ==================
    // lv/hv merge
    // ==================
    assign o_merged = i_lv_stat | i_hv_stat;

    // mask bit set means flag suppressed
    assign en1 = o_merged.status1 & ~i_mask1;
    assign en2 = o_merged.status2 & ~i_mask2;

    // ==================
    // fault flags
    // ==================
    // status1 bit 6 is reserved, no flag
    assign o_flt.bist_fail = en1[7];
    assign o_flt.pwm_mmerr = en1[5];
    assign o_flt.pwm_dterr = en1[4];
    assign o_flt.wdg_err   = en1[3];
    assign o_flt.com_err   = en1[2];
    assign o_flt.crc_err   = en1[1];
    assign o_flt.spi_err   = en1[0];

    assign o_flt.hv_scp_flt   = en2[7];
    assign o_flt.hv_desat_flt = en2[6];
    assign o_flt.hv_oc        = en2[5];
    assign o_flt.hv_ot        = en2[4];
    assign o_flt.hv_vcc_ov    = en2[3];
    assign o_flt.hv_vcc_uv    = en2[2];
    assign o_flt.lv_vsup_ov   = en2[1];
    assign o_flt.lv_vsup_uv   = en2[0];

    // any enabled fault raises the interrupt
    assign o_int = |o_flt;

endmodule

//--- design/lv_pkg.sv
// shared widths, opcode and register map enums, and frame/status structs for the lv register block
package lv_pkg;

    // ==================
    // widths
    // ==================
    localparam int REG_DW = 8;
    localparam int ADDR_W = 4;

    // command opcode, raw frame value 3 decodes as nop
    typedef enum logic [1:0] {
        OP_NOP = 2'd0,
        OP_RD  = 2'd1,
        OP_WR  = 2'd2
    } lv_op_e;

    // register map, addresses 9..15 unmapped
    typedef enum logic [ADDR_W-1:0] {
        A_STATUS1 = 4'd0,
        A_STATUS2 = 4'd1,
        A_STATUS3 = 4'd2,
        A_STATUS4 = 4'd3,
        A_BIST1   = 4'd4,
        A_BIST2   = 4'd5,
        A_MASK1   = 4'd6,
        A_MASK2   = 4'd7,
        A_CONFIG  = 4'd8
    } lv_addr_e;

    // ==================
    // structs
    // ==================
    // host frame, even parity over all 15 bits
    typedef struct packed {
        logic [1:0]        opcode;
        logic [ADDR_W-1:0] addr;
        logic [REG_DW-1:0] data;
        logic              parity;
    } lv_frame_t;

    typedef struct packed {
        lv_op_e            op;
        lv_addr_e          addr;
        logic [REG_DW-1:0] data;
        logic              mapped;
    } lv_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [REG_DW-1:0] data;
        logic              err;
    } lv_rsp_t;

    typedef struct packed {
        logic [REG_DW-1:0] status1;
        logic [REG_DW-1:0] status2;
        logic [REG_DW-1:0] status3;
        logic [REG_DW-1:0] status4;
        logic [REG_DW-1:0] bist1;
        logic [REG_DW-1:0] bist2;
    } lv_stat_t;

    // status1 flags, then status2 flags, msb first
    typedef struct packed {
        logic bist_fail;
        logic pwm_mmerr;
        logic pwm_dterr;
        logic wdg_err;
        logic com_err;
        logic crc_err;
        logic spi_err;
        logic hv_scp_flt;
        logic hv_desat_flt;
        logic hv_oc;
        logic hv_ot;
        logic hv_vcc_ov;
        logic hv_vcc_uv;
        logic lv_vsup_ov;
        logic lv_vsup_uv;
    } lv_flt_t;

endpackage
